// File: project.f
+incdir+hdl
hdl/fsync_pkg.sv
hdl/fsync_req_decode.sv
hdl/fsync_port_ctrl.sv
hdl/fsync_sync_rf.sv
hdl/fsync_fifo.sv
hdl/fsync_result.sv
hdl/fsync_node.sv
tb/tb_fsync_node.sv

// File: Bender.yml
package:
  name: fsync_node

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/fsync_pkg.sv
      - hdl/fsync_req_decode.sv
      - hdl/fsync_port_ctrl.sv
      - hdl/fsync_sync_rf.sv
      - hdl/fsync_fifo.sv
      - hdl/fsync_result.sv
      - hdl/fsync_node.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tb/tb_fsync_node.sv

// File: tb/tb_fsync_node.sv
// directed tests only; assumes a queue depth of 2 and 12 pending entries
`timescale 1ns/1ps
`include "fsync_defs.svh"

module tb_fsync_node
  import fsync_pkg::*;
();

  localparam int TIMEOUT  = 20;  // cycles per wait
  localparam int N_RANDOM = 6;

  logic       clk_i = 1'b0;
  logic       rst_ni;
  fsync_req_t req_i[`FSYNC_N_RX];
  logic       root_i[`FSYNC_N_RX];
  logic       local_i[`FSYNC_N_RX];
  logic       local_pop_i[`FSYNC_N_RX];
  logic       remote_pop_i[`FSYNC_N_RX];
  logic       local_empty_o[`FSYNC_N_RX];
  fsync_rsp_t local_rsp_o[`FSYNC_N_RX];
  logic       remote_empty_o[`FSYNC_N_RX];
  fsync_fwd_t remote_req_o[`FSYNC_N_RX];
  logic       detected_error_o[`FSYNC_N_RX];

  // requests prepared before they are launched
  fsync_req_t  staged_req[`FSYNC_N_RX];
  logic        staged_root[`FSYNC_N_RX];
  logic        staged_local[`FSYNC_N_RX];
  logic [31:0] rng_state = 32'h6885_06b8;
  int          errors = 0;
  int          checks = 0;
  int          tests  = 0;

  always #4 clk_i = ~clk_i;

  fsync_node dut0 (
    .clk_i            ( clk_i            ),
    .rst_ni           ( rst_ni           ),
    .req_i            ( req_i            ),
    .root_i           ( root_i           ),
    .local_i          ( local_i          ),
    .local_empty_o    ( local_empty_o    ),
    .local_rsp_o      ( local_rsp_o      ),
    .local_pop_i      ( local_pop_i      ),
    .remote_empty_o   ( remote_empty_o   ),
    .remote_req_o     ( remote_req_o     ),
    .remote_pop_i     ( remote_pop_i     ),
    .detected_error_o ( detected_error_o )
  );

  ////////////////////////////////////////////////////////////////////////////
  // helpers

  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state >> 16;  // upper half of the state
  endfunction

  function automatic fsync_req_t make_req(input logic [`FSYNC_ID_W-1:0] id,
                                          input logic [`FSYNC_AGGR_W-1:0] aggr,
                                          input logic [`FSYNC_SRC_W-1:0] src);
    fsync_req_t r;
    r.sync = 1'b1;
    r.aggr = aggr;
    r.id   = id;
    r.src  = src;
    return r;
  endfunction

  // top bit sets the level and lower bits are noise
  function automatic logic [`FSYNC_AGGR_W-1:0] mask_for_level(input int lvl,
                                                              input logic [31:0] noise);
    logic [`FSYNC_AGGR_W-1:0] top;
    top = `FSYNC_AGGR_W'(1) << lvl;
    return top | (noise[`FSYNC_AGGR_W-1:0] & (top - 1'b1));
  endfunction

  function automatic fsync_rsp_t expect_rsp(input logic err, input logic [`FSYNC_SRC_W-1:0] src);
    fsync_rsp_t r;
    r.wake  = 1'b1;
    r.error = err;
    r.dst   = src;
    return r;
  endfunction

  function automatic fsync_fwd_t expect_fwd(input fsync_req_t q);
    fsync_fwd_t f;
    f.sync = 1'b1;
    f.aggr = {1'b0, q.aggr[`FSYNC_AGGR_W-1:1]};  // lowest mask bit drops out
    f.id   = q.id;
    f.src  = {q.src, 2'b11};  // both side bits set
    return f;
  endfunction

  task automatic check_rsp(input string name, input fsync_rsp_t got, input fsync_rsp_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic check_fwd(input string name, input fsync_fwd_t got, input fsync_fwd_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic stage(input int p, input fsync_req_t r, input logic root, input logic lcl);
    staged_req[p]   = r;
    staged_root[p]  = root;
    staged_local[p] = lcl;
  endtask

  // one-cycle sync pulse on the enabled ports
  task automatic fire(input logic [1:0] en);
    @(posedge clk_i);
    for (int p = 0; p < `FSYNC_N_RX; p++) begin
      if (en[p]) begin
        req_i[p]   <= staged_req[p];
        root_i[p]  <= staged_root[p];
        local_i[p] <= staged_local[p];
      end
    end
    @(posedge clk_i);
    for (int p = 0; p < `FSYNC_N_RX; p++) begin
      req_i[p] <= '0;
    end
  endtask

  task automatic wait_local(input int p, output int cycles);
    cycles = 1;
    @(negedge clk_i);
    while (local_empty_o[p] && cycles < TIMEOUT) begin
      @(negedge clk_i);
      cycles++;
    end
    if (local_empty_o[p]) begin
      errors++;
      $display("no response arrived on local port %0d within %0d cycles", p, TIMEOUT);
    end
  endtask

  task automatic wait_remote(input int p);
    int n;
    n = 1;
    @(negedge clk_i);
    while (remote_empty_o[p] && n < TIMEOUT) begin
      @(negedge clk_i);
      n++;
    end
    if (remote_empty_o[p]) begin
      errors++;
      $display("no forward arrived on remote port %0d within %0d cycles", p, TIMEOUT);
    end
  endtask

  task automatic pop_local(input int p);
    @(posedge clk_i);
    local_pop_i[p] <= 1'b1;
    @(posedge clk_i);
    local_pop_i[p] <= 1'b0;
  endtask

  task automatic pop_remote(input int p);
    @(posedge clk_i);
    remote_pop_i[p] <= 1'b1;
    @(posedge clk_i);
    remote_pop_i[p] <= 1'b0;
  endtask

  task automatic report_test(input string name, input int errors_before);
    tests++;
    if (errors == errors_before) $display("%-20s ok", name);
    else $display("%-20s %0d errors", name, errors - errors_before);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // tests

  task automatic root_pairing();
    int e0, cyc;
    e0 = errors;
    stage(0, make_req(4'd5, 8'h04, 4'h3), 1'b1, 1'b0);
    stage(1, make_req(4'd5, 8'h06, 4'hA), 1'b1, 1'b0);
    fire(2'b01);
    repeat (4) @(posedge clk_i);  // first half only parks in the file
    @(negedge clk_i);
    check_bit("local_empty_o[0]", local_empty_o[0], 1'b1);
    fire(2'b10);
    wait_local(1, cyc);
    check_rsp("local_rsp_o[1]", local_rsp_o[1], expect_rsp(1'b0, 4'hA));
    pop_local(1);
    @(negedge clk_i);
    check_bit("local_empty_o[0]", local_empty_o[0], 1'b1);
    check_bit("local_empty_o[1]", local_empty_o[1], 1'b1);
    report_test("root_pairing", e0);
  endtask

  task automatic bypass_timing();
    int e0, cyc;
    e0 = errors;
    stage(0, make_req(4'd2, 8'h01, 4'h7), 1'b1, 1'b0);
    fire(2'b01);
    wait_local(0, cyc);
    if (cyc != 2) begin
      errors++;
      $display("bypass response took %0d cycles instead of 2", cyc);
    end
    check_rsp("local_rsp_o[0]", local_rsp_o[0], expect_rsp(1'b0, 4'h7));
    pop_local(0);
    report_test("bypass_timing", e0);
  endtask

  task automatic remote_aggregation();
    int         e0;
    fsync_req_t r1;
    fsync_fwd_t want;
    e0 = errors;
    r1 = make_req(4'd9, 8'h2C, 4'h6);
    want.sync = 1'b1;
    want.aggr = 8'h16;  // level 5 goes up as level 4
    want.id   = 4'd9;
    want.src  = 6'h1B;  // source 6 then both side bits
    stage(0, make_req(4'd9, 8'h30, 4'h1), 1'b0, 1'b1);
    stage(1, r1, 1'b0, 1'b1);
    fire(2'b11);  // port 1 completes the pair in the same cycle
    wait_remote(1);
    check_fwd("remote_req_o[1]", remote_req_o[1], want);
    pop_remote(1);
    @(negedge clk_i);
    check_bit("remote_empty_o[0]", remote_empty_o[0], 1'b1);
    check_bit("remote_empty_o[1]", remote_empty_o[1], 1'b1);
    check_bit("local_empty_o[0]", local_empty_o[0], 1'b1);
    check_bit("local_empty_o[1]", local_empty_o[1], 1'b1);
    report_test("remote_aggregation", e0);
  endtask

  task automatic request_errors();
    int e0, cyc;
    e0 = errors;
    // id beyond the file
    stage(0, make_req(4'd12, 8'h02, 4'h2), 1'b1, 1'b0);
    fire(2'b01);
    wait_local(0, cyc);
    check_rsp("local_rsp_o[0]", local_rsp_o[0], expect_rsp(1'b1, 4'h2));
    pop_local(0);
    // level 3 pending then a level 2 partner
    stage(0, make_req(4'd7, 8'h08, 4'h4), 1'b1, 1'b0);
    stage(1, make_req(4'd7, 8'h04, 4'h5), 1'b1, 1'b0);
    fire(2'b01);
    repeat (3) @(posedge clk_i);
    fire(2'b10);
    wait_local(1, cyc);
    check_rsp("local_rsp_o[1]", local_rsp_o[1], expect_rsp(1'b1, 4'h5));
    pop_local(1);
    // correct partner still finds the entry
    stage(1, make_req(4'd7, 8'h0F, 4'h5), 1'b1, 1'b0);
    fire(2'b10);
    wait_local(1, cyc);
    check_rsp("local_rsp_o[1]", local_rsp_o[1], expect_rsp(1'b0, 4'h5));
    pop_local(1);
    @(negedge clk_i);
    check_bit("local_empty_o[0]", local_empty_o[0], 1'b1);
    check_bit("local_empty_o[1]", local_empty_o[1], 1'b1);
    report_test("request_errors", e0);
  endtask

  task automatic fifo_misuse();
    int   e0, n;
    logic seen;
    e0 = errors;
    @(posedge clk_i);
    local_pop_i[0] <= 1'b1;
    @(negedge clk_i);
    check_bit("detected_error_o[0]", detected_error_o[0], 1'b1);
    check_bit("detected_error_o[1]", detected_error_o[1], 1'b0);
    // pop on the empty forward queue of port 1
    @(posedge clk_i);
    local_pop_i[0]  <= 1'b0;
    remote_pop_i[1] <= 1'b1;
    @(negedge clk_i);
    check_bit("detected_error_o[0]", detected_error_o[0], 1'b0);
    check_bit("detected_error_o[1]", detected_error_o[1], 1'b1);
    @(posedge clk_i);
    remote_pop_i[1] <= 1'b0;
    @(negedge clk_i);
    check_bit("detected_error_o[1]", detected_error_o[1], 1'b0);
    // depth 2 so the third push overflows
    for (int k = 0; k < 3; k++) begin
      stage(0, make_req(4'd1, 8'h01, 4'(k + 1)), 1'b1, 1'b0);
      fire(2'b01);
      seen = 1'b0;
      for (int c = 0; c < 4; c++) begin
        @(negedge clk_i);
        seen = seen | detected_error_o[0];
      end
      check_bit("detected_error_o[0]", seen, (k == 2));
    end
    n = 0;
    for (int k = 0; k < 4; k++) begin
      @(negedge clk_i);
      if (local_empty_o[0]) break;
      check_rsp("local_rsp_o[0]", local_rsp_o[0], expect_rsp(1'b0, 4'(n + 1)));
      pop_local(0);
      n++;
    end
    if (n != 2) begin
      errors++;
      $display("read %0d responses from a full queue instead of 2", n);
    end
    report_test("fifo_misuse", e0);
  endtask

  task automatic random_pairs();
    int                    e0, cyc, lvl;
    logic [`FSYNC_ID_W-1:0] id;
    fsync_req_t            r0, r1;
    e0 = errors;
    for (int k = 0; k < N_RANDOM; k++) begin
      id  = `FSYNC_ID_W'(next_rand() % `FSYNC_N_REGS);
      lvl = 1 + int'(next_rand() % (`FSYNC_AGGR_W - 1));
      r0  = make_req(id, mask_for_level(lvl, next_rand()), `FSYNC_SRC_W'(next_rand()));
      r1  = make_req(id, mask_for_level(lvl, next_rand()), `FSYNC_SRC_W'(next_rand()));
      // root pair with port 0 first
      stage(0, r0, 1'b1, 1'b0);
      stage(1, r1, 1'b1, 1'b0);
      fire(2'b01);
      fire(2'b10);
      wait_local(1, cyc);
      check_rsp("local_rsp_o[1]", local_rsp_o[1], expect_rsp(1'b0, r1.src));
      pop_local(1);
      @(negedge clk_i);
      check_bit("local_empty_o[0]", local_empty_o[0], 1'b1);
      // same pair sent upward
      stage(0, r0, 1'b0, 1'b1);
      stage(1, r1, 1'b0, 1'b1);
      fire(2'b11);
      wait_remote(1);
      check_fwd("remote_req_o[1]", remote_req_o[1], expect_fwd(r1));
      pop_remote(1);
      @(negedge clk_i);
      check_bit("remote_empty_o[0]", remote_empty_o[0], 1'b1);
      check_bit("remote_empty_o[1]", remote_empty_o[1], 1'b1);
    end
    report_test("random_pairs", e0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence

  initial begin
    rst_ni = 1'b0;
    for (int p = 0; p < `FSYNC_N_RX; p++) begin
      req_i[p]        = '0;
      root_i[p]       = 1'b0;
      local_i[p]      = 1'b0;
      local_pop_i[p]  = 1'b0;
      remote_pop_i[p] = 1'b0;
    end
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    for (int p = 0; p < `FSYNC_N_RX; p++) begin
      check_bit("local_empty_o", local_empty_o[p], 1'b1);
      check_bit("remote_empty_o", remote_empty_o[p], 1'b1);
      check_bit("detected_error_o", detected_error_o[p], 1'b0);
    end
    root_pairing();
    bypass_timing();
    remote_aggregation();
    request_errors();
    fifo_misuse();
    random_pairs();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: hdl/fsync_node.sv
// 1d node with two children; no back-pressure on requests, outputs are read as queues
`timescale 1ns/1ps
`include "fsync_defs.svh"

module fsync_node
  import fsync_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  fsync_req_t req_i[`FSYNC_N_RX],
  input  logic       root_i[`FSYNC_N_RX],
  input  logic       local_i[`FSYNC_N_RX],
  output logic       local_empty_o[`FSYNC_N_RX],
  output fsync_rsp_t local_rsp_o[`FSYNC_N_RX],
  input  logic       local_pop_i[`FSYNC_N_RX],
  output logic       remote_empty_o[`FSYNC_N_RX],
  output fsync_fwd_t remote_req_o[`FSYNC_N_RX],
  input  logic       remote_pop_i[`FSYNC_N_RX],
  output logic       detected_error_o[`FSYNC_N_RX]
);

  fsync_dec_t dec[`FSYNC_N_RX];
  logic       check_local[`FSYNC_N_RX];
  logic       check_remote[`FSYNC_N_RX];
  logic       present[`FSYNC_N_RX];
  logic       bypass[`FSYNC_N_RX];
  logic       sig_err[`FSYNC_N_RX];
  logic       push_local[`FSYNC_N_RX];
  logic       push_remote[`FSYNC_N_RX];
  logic       rsp_err[`FSYNC_N_RX];

  ////////////////////////////////////////////////////////////////////////////
  // decode and control, one per child

  for (genvar i = 0; i < `FSYNC_N_RX; i++) begin : gen_port
    fsync_req_decode i_dec (
      .req_i ( req_i[i] ),
      .dec_o ( dec[i]   )
    );

    fsync_port_ctrl i_ctrl (
      .clk_i          ( clk_i           ),
      .rst_ni         ( rst_ni          ),
      .dec_i          ( dec[i]          ),
      .root_i         ( root_i[i]       ),
      .local_i        ( local_i[i]      ),
      .present_i      ( present[i]      ),
      .bypass_i       ( bypass[i]       ),
      .sig_err_i      ( sig_err[i]      ),
      .check_local_o  ( check_local[i]  ),
      .check_remote_o ( check_remote[i] ),
      .push_local_o   ( push_local[i]   ),
      .push_remote_o  ( push_remote[i]  ),
      .rsp_err_o      ( rsp_err[i]      )
    );
  end

  // shared so that siblings can pair
  fsync_sync_rf i_rf (
    .clk_i          ( clk_i        ),
    .rst_ni         ( rst_ni       ),
    .dec_i          ( dec          ),
    .check_local_i  ( check_local  ),
    .check_remote_i ( check_remote ),
    .present_o      ( present      ),
    .bypass_o       ( bypass       ),
    .sig_err_o      ( sig_err      )
  );

  fsync_result i_result (
    .clk_i            ( clk_i            ),
    .rst_ni           ( rst_ni           ),
    .req_i            ( req_i            ),
    .push_local_i     ( push_local       ),
    .push_remote_i    ( push_remote      ),
    .rsp_err_i        ( rsp_err          ),
    .local_pop_i      ( local_pop_i      ),
    .remote_pop_i     ( remote_pop_i     ),
    .local_empty_o    ( local_empty_o    ),
    .local_rsp_o      ( local_rsp_o      ),
    .remote_empty_o   ( remote_empty_o   ),
    .remote_req_o     ( remote_req_o     ),
    .detected_error_o ( detected_error_o )
  );

endmodule

// File: hdl/fsync_result.sv
// the request is captured on every sync; a later sync lands on the same edge as the push
`timescale 1ns/1ps
`include "fsync_defs.svh"

module fsync_result
  import fsync_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  fsync_req_t req_i[`FSYNC_N_RX],
  input  logic       push_local_i[`FSYNC_N_RX],
  input  logic       push_remote_i[`FSYNC_N_RX],
  input  logic       rsp_err_i[`FSYNC_N_RX],
  input  logic       local_pop_i[`FSYNC_N_RX],
  input  logic       remote_pop_i[`FSYNC_N_RX],
  output logic       local_empty_o[`FSYNC_N_RX],
  output fsync_rsp_t local_rsp_o[`FSYNC_N_RX],
  output logic       remote_empty_o[`FSYNC_N_RX],
  output fsync_fwd_t remote_req_o[`FSYNC_N_RX],
  output logic       detected_error_o[`FSYNC_N_RX]
);

  for (genvar i = 0; i < `FSYNC_N_RX; i++) begin : gen_port
    fsync_req_t req_q;
    fsync_rsp_t rsp;
    fsync_fwd_t fwd;
    logic       local_full, remote_full;

    always_ff @(posedge clk_i) begin
      if (req_i[i].sync) begin
        req_q <= req_i[i];
      end
    end

    ////////////////////////////////////////////////////////////////////////////
    // payloads

    assign rsp.wake  = 1'b1;
    assign rsp.error = rsp_err_i[i];
    assign rsp.dst   = req_q.src;

    assign fwd.sync = req_q.sync;
    assign fwd.aggr = req_q.aggr >> 1;  // one level up
    assign fwd.id   = req_q.id;
    assign fwd.src  = {req_q.src, `FSYNC_SD_BOTH};

    fsync_fifo #(
      .FIFO_DEPTH ( `FSYNC_FIFO_DEPTH ),
      .fifo_t     ( fsync_rsp_t       )
    ) i_local_fifo (
      .clk_i     ( clk_i            ),
      .rst_ni    ( rst_ni           ),
      .push_i    ( push_local_i[i]  ),
      .element_i ( rsp              ),
      .pop_i     ( local_pop_i[i]   ),
      .element_o ( local_rsp_o[i]   ),
      .empty_o   ( local_empty_o[i] ),
      .full_o    ( local_full       )
    );

    fsync_fifo #(
      .FIFO_DEPTH ( `FSYNC_FIFO_DEPTH ),
      .fifo_t     ( fsync_fwd_t       )
    ) i_remote_fifo (
      .clk_i     ( clk_i             ),
      .rst_ni    ( rst_ni            ),
      .push_i    ( push_remote_i[i]  ),
      .element_i ( fwd               ),
      .pop_i     ( remote_pop_i[i]   ),
      .element_o ( remote_req_o[i]   ),
      .empty_o   ( remote_empty_o[i] ),
      .full_o    ( remote_full       )
    );

    // misuse of either queue
    assign detected_error_o[i] = (local_empty_o[i] & local_pop_i[i])
                               | (local_full & push_local_i[i])
                               | (remote_empty_o[i] & remote_pop_i[i])
                               | (remote_full & push_remote_i[i]);
  end

endmodule

// File: hdl/fsync_fifo.sv
// drops a push when full and a pop when empty; the caller flags both, the head is stale when empty
`timescale 1ns/1ps
`include "fsync_defs.svh"

module fsync_fifo #(
  parameter int unsigned FIFO_DEPTH = `FSYNC_FIFO_DEPTH,
  parameter type         fifo_t     = logic
)(
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  push_i,
  input  fifo_t element_i,
  input  logic  pop_i,
  output fifo_t element_o,
  output logic  empty_o,
  output logic  full_o
);

  localparam int unsigned PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);

  fifo_t            mem_q[FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             do_push, do_pop;

  assign empty_o   = (count_q == '0);
  assign full_o    = (count_q == CNT_W'(FIFO_DEPTH));
  assign do_push   = push_i & ~full_o;
  assign do_pop    = pop_i & ~empty_o;
  assign element_o = mem_q[rd_ptr_q];  // head

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + CNT_W'(do_push) - CNT_W'(do_pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= element_i;
    end
  end

endmodule

// File: hdl/fsync_sync_rf.sv
// entries hold one pending barrier per id and path; port 0 wins when both ports hit one entry
`timescale 1ns/1ps
`include "fsync_defs.svh"

module fsync_sync_rf
  import fsync_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  fsync_dec_t dec_i[`FSYNC_N_RX],
  input  logic       check_local_i[`FSYNC_N_RX],
  input  logic       check_remote_i[`FSYNC_N_RX],
  output logic       present_o[`FSYNC_N_RX],
  output logic       bypass_o[`FSYNC_N_RX],
  output logic       sig_err_o[`FSYNC_N_RX]
);

  // path 0 is local and path 1 is remote
  logic [1:0][`FSYNC_N_REGS-1:0]                     pend_q, pend_d;
  logic [1:0][`FSYNC_N_REGS-1:0][`FSYNC_LEVEL_W-1:0] lvl_q, lvl_d;

  logic present_d[`FSYNC_N_RX];
  logic bypass_d[`FSYNC_N_RX];
  logic sig_err_d[`FSYNC_N_RX];

  ////////////////////////////////////////////////////////////////////////////
  // pairing rule

  // ports in index order on a running copy so port 1 sees port 0
  always_comb begin
    logic chk;
    pend_d = pend_q;
    lvl_d  = lvl_q;
    for (int p = 0; p < `FSYNC_N_RX; p++) begin
      present_d[p] = 1'b0;
      bypass_d[p]  = 1'b0;
      sig_err_d[p] = 1'b0;
      for (int path = 0; path < 2; path++) begin
        chk = (path == 0) ? check_local_i[p] : check_remote_i[p];
        if (chk && !dec_i[p].id_err) begin
          if (dec_i[p].level == '0) begin
            bypass_d[p] = 1'b1;  // no partner needed
          end else if (pend_d[path][dec_i[p].id]) begin
            if (lvl_d[path][dec_i[p].id] == dec_i[p].level) begin
              present_d[p]                = 1'b1;
              pend_d[path][dec_i[p].id] = 1'b0;
            end else begin
              sig_err_d[p] = 1'b1;  // level mismatch leaves the entry
            end
          end else begin
            pend_d[path][dec_i[p].id] = 1'b1;
            lvl_d[path][dec_i[p].id]  = dec_i[p].level;
          end
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // state and answers

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pend_q <= '0;
      for (int p = 0; p < `FSYNC_N_RX; p++) begin
        present_o[p] <= 1'b0;
        bypass_o[p]  <= 1'b0;
        sig_err_o[p] <= 1'b0;
      end
    end else begin
      pend_q <= pend_d;
      for (int p = 0; p < `FSYNC_N_RX; p++) begin
        present_o[p] <= present_d[p];
        bypass_o[p]  <= bypass_d[p];
        sig_err_o[p] <= sig_err_d[p];
      end
    end
  end

  // level store per entry and path
  always_ff @(posedge clk_i) begin
    lvl_q <= lvl_d;
  end

endmodule

// File: hdl/fsync_port_ctrl.sv
// one request in flight per port; a sync that arrives outside IDLE is dropped silently
`timescale 1ns/1ps

module fsync_port_ctrl
  import fsync_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  fsync_dec_t dec_i,
  input  logic       root_i,
  input  logic       local_i,
  input  logic       present_i,
  input  logic       bypass_i,
  input  logic       sig_err_i,
  output logic       check_local_o,
  output logic       check_remote_o,
  output logic       push_local_o,
  output logic       push_remote_o,
  output logic       rsp_err_o
);

  fsync_state_e state_q, state_d;
  logic         id_err_q;
  logic         rsp_err;

  assign rsp_err   = id_err_q | sig_err_i;  // valid in ROOT/AGGR only
  assign rsp_err_o = rsp_err;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= IDLE;
      id_err_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (check_local_o || check_remote_o) begin
        id_err_q <= dec_i.id_err;  // kept for the push cycle
      end
    end
  end

  always_comb begin
    state_d        = state_q;
    check_local_o  = 1'b0;
    check_remote_o = 1'b0;
    push_local_o   = 1'b0;
    push_remote_o  = 1'b0;
    case (state_q)
      IDLE: begin
        if (dec_i.valid && root_i) begin
          state_d       = ROOT;
          check_local_o = 1'b1;
        end else if (dec_i.valid && local_i) begin
          state_d        = AGGR;
          check_remote_o = 1'b1;
        end
      end
      ROOT: begin
        state_d      = IDLE;
        push_local_o = present_i | bypass_i | rsp_err;
      end
      AGGR: begin
        state_d = IDLE;
        // errors go back down, good pairs go up
        if (rsp_err) begin
          push_local_o = 1'b1;
        end else begin
          push_remote_o = present_i | bypass_i;
        end
      end
      default: state_d = IDLE;
    endcase
  end

endmodule

// File: hdl/fsync_req_decode.sv
// combinational only; an empty aggregation mask decodes to level 0, same as mask 1
`timescale 1ns/1ps
`include "fsync_defs.svh"

module fsync_req_decode
  import fsync_pkg::*;
(
  input  fsync_req_t req_i,
  output fsync_dec_t dec_o
);

  logic [`FSYNC_LEVEL_W-1:0] level;

  ////////////////////////////////////////////////////////////////////////////
  // level encoder

  // scan upward so the highest set bit is the one that sticks
  always_comb begin
    level = '0;
    for (int j = 0; j < `FSYNC_AGGR_W; j++) begin
      if (req_i.aggr[j]) begin
        level = `FSYNC_LEVEL_W'(j);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // decoded request

  assign dec_o.valid  = req_i.sync;
  assign dec_o.level  = level;
  assign dec_o.id     = req_i.id;
  assign dec_o.id_err = (req_i.id >= `FSYNC_ID_W'(`FSYNC_N_REGS));  // beyond the file

endmodule

// File: hdl/fsync_pkg.sv
// types for the 1d sync node; the forward source is always two bits wider than the request source
`include "fsync_defs.svh"

package fsync_pkg;

  // sync request from a child with a single-cycle sync pulse
  typedef struct packed {
    logic                     sync;
    logic [`FSYNC_AGGR_W-1:0] aggr;
    logic [`FSYNC_ID_W-1:0]   id;
    logic [`FSYNC_SRC_W-1:0]  src;
  } fsync_req_t;

  // wake response back to the requesting child
  typedef struct packed {
    logic                    wake;
    logic                    error;
    logic [`FSYNC_SRC_W-1:0] dst;
  } fsync_rsp_t;

  // request forwarded one level up the tree
  typedef struct packed {
    logic                     sync;
    logic [`FSYNC_AGGR_W-1:0] aggr;
    logic [`FSYNC_ID_W-1:0]   id;
    logic [`FSYNC_SRC_W+1:0]  src;  // source plus side bits
  } fsync_fwd_t;

  // decoded request
  typedef struct packed {
    logic                      valid;
    logic [`FSYNC_LEVEL_W-1:0] level;
    logic [`FSYNC_ID_W-1:0]    id;
    logic                      id_err;
  } fsync_dec_t;

  typedef enum logic [1:0] {
    IDLE,
    ROOT,
    AGGR
  } fsync_state_e;

endpackage

// File: hdl/fsync_defs.svh
// widths and counts for a 1d node only; changing FSYNC_N_RX needs a matching top level
`ifndef FSYNC_DEFS_SVH
`define FSYNC_DEFS_SVH

// request fields
`define FSYNC_AGGR_W 8
`define FSYNC_LEVEL_W 3
`define FSYNC_ID_W 4
`define FSYNC_SRC_W 4

// ids at or above the entry count are rejected
`define FSYNC_N_REGS 12

// child ports of the node
`define FSYNC_N_RX 2

// default queue depth for responses and forwards
`define FSYNC_FIFO_DEPTH 2

// side bits appended to the source of a forwarded request
`define FSYNC_SD_BOTH 2'b11

`endif
